// ==== common/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int WORD_BITS = 32;  // Data and address width
    localparam int REG_BITS  = 5;   // Register index width

    // Memory access width of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // Execute-stage result entering the memory stage
    typedef struct packed {
        logic [WORD_BITS-1:0] alu_result;     // Memory address or ALU value
        logic [WORD_BITS-1:0] store_data;     // Register B value for stores
        logic [WORD_BITS-1:0] branch_target;  // Next PC when branch is taken
        logic [REG_BITS-1:0]  dest;           // rd or rt
        logic [WORD_BITS-1:0] pc;             // Base of the link value
        logic                 mem_read;
        logic                 mem_write;
        logic                 load_unsigned;  // Zero-extend loaded data
        logic                 mem_to_reg;     // Write back load data
        logic                 reg_write;
        logic                 link_r31;       // JAL style link to r31
        logic                 branch;
        logic                 zero;           // ALU zero flag
        logic                 halt;
        access_size_e         size;
    } ex_mem_t;

    // Write-back bundle leaving the memory stage
    typedef struct packed {
        logic [WORD_BITS-1:0] wb_data;
        logic [REG_BITS-1:0]  dest;
        logic                 reg_write;
        logic                 halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== src/pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire logic i_clock,
    input  wire logic i_arst_n,
    input  wire logic i_valid,
    output logic      o_ready,
    input  wire T     i_data,
    output logic      o_valid,
    input  wire logic i_ready,
    output T          o_data
);

    // Empty or draining this cycle, so a new item can land on the same edge
    assign o_ready = ~o_valid | i_ready;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid && o_ready) begin
            o_data <= i_data;  // Held while stalled
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage/mem_stage_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_ctrl
    import mem_stage_pkg::*;
(
    input  wire logic                 i_clock,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_stage_valid,   // Input register holds an item
    input  wire ex_mem_t              i_stage,
    input  wire logic                 i_out_ready,     // Output register can take an item
    input  wire logic                 i_up_valid,      // Upstream valid, unmasked
    output logic                      o_advance,
    output logic                      o_stage_ready,   // Release for the input register
    output logic                      o_up_ready,
    output logic                      o_mem_we,
    output logic                      o_branch_taken,
    output logic [WORD_BITS-1:0]      o_branch_addr,
    output logic                      o_halted
);

    logic stage_phantom;  // Stage item was loaded while upstream saw ready low
    logic halt_block;
    logic in_ready;

    // A halt item sitting in the stage already closes the input
    assign halt_block = o_halted | (i_stage_valid & i_stage.halt);

    // Items loaded behind a closed input are discarded without effect
    assign o_stage_ready = i_out_ready | stage_phantom;
    assign in_ready      = ~i_stage_valid | o_stage_ready;  // Same as input register ready
    assign o_up_ready    = in_ready & ~halt_block;

    assign o_advance = i_stage_valid & ~stage_phantom & i_out_ready;

    assign o_mem_we       = o_advance & i_stage.mem_write;   // Store commits on advance
    assign o_branch_taken = o_advance & i_stage.branch & i_stage.zero;
    assign o_branch_addr  = i_stage.branch_target;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            stage_phantom <= 1'b0;
        end else if (i_up_valid && in_ready) begin
            stage_phantom <= halt_block;  // Tag whatever the input register loads
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_halted <= 1'b0;
        end else if (o_advance && i_stage.halt) begin
            o_halted <= 1'b1;  // Sticky until reset
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage/data_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_memory
    import mem_stage_pkg::*;
#(
    parameter int DM_ADDR_BITS = 7
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_arst_n,
    input  wire logic                    i_we,
    input  wire access_size_e            i_size,
    input  wire logic [DM_ADDR_BITS-1:0] i_addr,
    input  wire logic [WORD_BITS-1:0]    i_wdata,
    output logic      [WORD_BITS-1:0]    o_rword,      // Aligned word at i_addr
    input  wire logic                    i_dbg_enable,
    input  wire logic [DM_ADDR_BITS-1:0] i_dbg_addr,
    output logic      [WORD_BITS-1:0]    o_dbg_word
);

    localparam int DEPTH = 2 ** DM_ADDR_BITS;  // Bytes

    logic [7:0]              mem [DEPTH];
    logic [3:0]              lane_mask;
    logic [WORD_BITS-1:0]    wdata_rep;
    logic [DM_ADDR_BITS-3:0] word_idx;
    logic [DM_ADDR_BITS-3:0] dbg_idx;
    logic [WORD_BITS-1:0]    dbg_word;

    assign word_idx = i_addr[DM_ADDR_BITS-1:2];
    assign dbg_idx  = i_dbg_addr[DM_ADDR_BITS-1:2];

    // Little-endian lane enables and replicated store data
    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                lane_mask = 4'b0001 << i_addr[1:0];
                wdata_rep = {4{i_wdata[7:0]}};
            end
            SIZE_HALF: begin
                lane_mask = i_addr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{i_wdata[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;  // Word access
                wdata_rep = i_wdata;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (i_we) begin
            for (int l = 0; l < 4; l++) begin
                if (lane_mask[l]) begin
                    mem[{word_idx, 2'(l)}] <= wdata_rep[8*l +: 8];
                end
            end
        end
    end

    // Both read ports return the whole aligned word
    always_comb begin
        for (int l = 0; l < 4; l++) begin
            o_rword[8*l +: 8]  = mem[{word_idx, 2'(l)}];
            dbg_word[8*l +: 8] = mem[{dbg_idx, 2'(l)}];
        end
    end

    assign o_dbg_word = i_dbg_enable ? dbg_word : '0;

endmodule

`default_nettype wire

// ==== mem_stage/load_extend.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_extend
    import mem_stage_pkg::*;
(
    input  wire logic [WORD_BITS-1:0] i_rword,     // Aligned memory word
    input  wire logic [1:0]           i_addr_low,
    input  wire access_size_e         i_size,
    input  wire logic                 i_unsigned,
    output logic      [WORD_BITS-1:0] o_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = i_rword[8*i_addr_low +: 8];
    assign half_sel = i_addr_low[1] ? i_rword[31:16] : i_rword[15:0];  // Bit 0 ignored

    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                if (i_unsigned) begin
                    o_data = {24'h000000, byte_sel};
                end else begin
                    o_data = {{24{byte_sel[7]}}, byte_sel};
                end
            end
            SIZE_HALF: begin
                if (i_unsigned) begin
                    o_data = {16'h0000, half_sel};
                end else begin
                    o_data = {{16{half_sel[15]}}, half_sel};
                end
            end
            default: begin
                o_data = i_rword;  // Word load
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/writeback_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_select
    import mem_stage_pkg::*;
(
    input  wire ex_mem_t              i_stage,
    input  wire logic [WORD_BITS-1:0] i_load_data,
    output mem_wb_t                   o_wb
);

    logic [REG_BITS-1:0] dest;

    assign dest = i_stage.link_r31 ? REG_BITS'(31) : i_stage.dest;  // Link always targets r31

    always_comb begin
        if (i_stage.link_r31) begin
            o_wb.wb_data = i_stage.pc + WORD_BITS'(8);  // Return past the delay slot
        end else if (i_stage.mem_to_reg) begin
            o_wb.wb_data = i_load_data;
        end else begin
            o_wb.wb_data = i_stage.alu_result;
        end
        o_wb.dest      = dest;
        o_wb.reg_write = i_stage.reg_write & (dest != '0);  // r0 is hardwired
        o_wb.halt      = i_stage.halt;
    end

endmodule

`default_nettype wire

// ==== src/mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_top
    import mem_stage_pkg::*;
#(
    parameter int DM_ADDR_BITS = 7
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_arst_n,
    input  wire logic                    i_in_valid,
    output logic                         o_in_ready,
    input  wire ex_mem_t                 i_in,
    output logic                         o_out_valid,
    input  wire logic                    i_out_ready,
    output mem_wb_t                      o_out,
    output logic                         o_branch_taken,  // To fetch PC mux
    output logic      [WORD_BITS-1:0]    o_branch_addr,
    output logic                         o_halted,
    input  wire logic                    i_dbg_enable,    // Debug unit word read
    input  wire logic [DM_ADDR_BITS-1:0] i_dbg_addr,
    output logic      [WORD_BITS-1:0]    o_dbg_word
);

    logic                 stage_valid;
    ex_mem_t              stage;
    logic                 stage_ready;
    logic                 advance;
    logic                 out_reg_ready;
    logic                 mem_we;
    logic [WORD_BITS-1:0] rword;
    logic [WORD_BITS-1:0] load_data;
    mem_wb_t              wb;

    pipe_reg #(.T(ex_mem_t)) u_in_reg (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_valid  (i_in_valid),
        .o_ready  (),             // Mirrored by the control block
        .i_data   (i_in),
        .o_valid  (stage_valid),
        .i_ready  (stage_ready),
        .o_data   (stage)
    );

    mem_stage_ctrl u_ctrl (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_stage_valid  (stage_valid),
        .i_stage        (stage),
        .i_out_ready    (out_reg_ready),
        .i_up_valid     (i_in_valid),
        .o_advance      (advance),
        .o_stage_ready  (stage_ready),
        .o_up_ready     (o_in_ready),
        .o_mem_we       (mem_we),
        .o_branch_taken (o_branch_taken),
        .o_branch_addr  (o_branch_addr),
        .o_halted       (o_halted)
    );

    data_memory #(.DM_ADDR_BITS(DM_ADDR_BITS)) u_dmem (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_we         (mem_we),
        .i_size       (stage.size),
        .i_addr       (stage.alu_result[DM_ADDR_BITS-1:0]),
        .i_wdata      (stage.store_data),
        .o_rword      (rword),
        .i_dbg_enable (i_dbg_enable),
        .i_dbg_addr   (i_dbg_addr),
        .o_dbg_word   (o_dbg_word)
    );

    load_extend u_load_ext (
        .i_rword    (rword),
        .i_addr_low (stage.alu_result[1:0]),
        .i_size     (stage.size),
        .i_unsigned (stage.load_unsigned),
        .o_data     (load_data)
    );

    writeback_select u_wb_sel (
        .i_stage     (stage),
        .i_load_data (load_data),
        .o_wb        (wb)
    );

    pipe_reg #(.T(mem_wb_t)) u_out_reg (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_valid  (advance),
        .o_ready  (out_reg_ready),
        .i_data   (wb),
        .o_valid  (o_out_valid),
        .i_ready  (i_out_ready),
        .o_data   (o_out)
    );

endmodule

`default_nettype wire

// ==== tests/mem_top_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_top_assertions
    import mem_stage_pkg::*;
(
    input wire logic    i_clock,
    input wire logic    i_arst_n,
    input wire logic    i_in_valid,
    input wire logic    o_in_ready,
    input wire ex_mem_t i_in,
    input wire logic    o_out_valid,
    input wire logic    i_out_ready,
    input wire mem_wb_t o_out,
    input wire logic    o_halted
);

    in_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_in_valid && !o_in_ready) |=> (!i_in_valid || $stable(i_in)))
        else $error("i_in changed while its valid was held");

    // A stalled output keeps both valid and data
    out_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out)))
        else $error("o_out changed while held");

    out_latency: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        ($past(i_in_valid && o_in_ready) && i_out_ready) |=> o_out_valid)
        else $error("accepted item late at the output");

    halt_closed: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_halted |-> !o_in_ready)
        else $error("o_in_ready high while halted");

endmodule

`default_nettype wire

// ==== tests/tb_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_top
    import mem_stage_pkg::*;
();

    localparam int DM_ADDR_BITS   = 7;
    localparam int SEED           = 84;
    localparam int KIND_STORE     = 0;
    localparam int KIND_LOAD      = 1;
    localparam int KIND_ALU       = 2;
    localparam int KIND_LINK      = 3;
    localparam int KIND_BRANCH    = 4;
    localparam int KIND_HALT      = 5;
    localparam int N_PAIRS        = 60;  // Store and load pairs
    localparam int N_ALU          = 60;
    localparam int N_MIX          = 150;
    localparam int N_BRANCH       = 40;
    localparam int N_STORES       = 40;
    localparam int N_DEBUG        = 20;
    localparam int N_PRE_HALT     = 10;
    localparam int TOTAL_ITEMS    = 2 * N_PAIRS + N_ALU + N_MIX + N_BRANCH + N_STORES
                                    + N_PRE_HALT + 1;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_ITEMS + 200;

    logic                    clock;
    logic                    arst_n;
    logic                    in_valid;
    logic                    in_ready;
    ex_mem_t                 in_item;
    logic                    out_valid;
    logic                    out_ready;
    mem_wb_t                 out_item;
    logic                    branch_taken;
    logic [WORD_BITS-1:0]    branch_addr;
    logic                    halted;
    logic                    dbg_enable;
    logic [DM_ADDR_BITS-1:0] dbg_addr;
    logic [WORD_BITS-1:0]    dbg_word;

    logic [7:0]           ref_mem [2**DM_ADDR_BITS];  // Little-endian byte image
    mem_wb_t              exp_q[$];
    logic [WORD_BITS-1:0] branch_q[$];                // Targets of taken branches
    mem_wb_t              exp_wb;
    mem_wb_t              held_item;
    logic                 out_hold = 1'b0;
    logic                 halted_seen = 1'b0;
    int                   ready_pct = 75;             // Sink readiness in percent
    int                   cycle_count = 0;
    int                   check_count = 0;
    int                   error_count = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    mem_top #(.DM_ADDR_BITS(DM_ADDR_BITS)) dut0 (
        .i_clock        (clock),
        .i_arst_n       (arst_n),
        .i_in_valid     (in_valid),
        .o_in_ready     (in_ready),
        .i_in           (in_item),
        .o_out_valid    (out_valid),
        .i_out_ready    (out_ready),
        .o_out          (out_item),
        .o_branch_taken (branch_taken),
        .o_branch_addr  (branch_addr),
        .o_halted       (halted),
        .i_dbg_enable   (dbg_enable),
        .i_dbg_addr     (dbg_addr),
        .o_dbg_word     (dbg_word)
    );

    bind mem_top mem_top_assertions u_assertions (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_in        (i_in),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_out       (o_out),
        .o_halted    (o_halted)
    );

    always #5 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    task automatic note_error(input string msg);
        error_count++;
        $display("[ERROR] t=%0t %s", $time, msg);
    endtask

    function automatic logic [WORD_BITS-1:0] ref_word(input logic [DM_ADDR_BITS-1:0] a);
        return {ref_mem[{a[DM_ADDR_BITS-1:2], 2'd3}], ref_mem[{a[DM_ADDR_BITS-1:2], 2'd2}],
                ref_mem[{a[DM_ADDR_BITS-1:2], 2'd1}], ref_mem[{a[DM_ADDR_BITS-1:2], 2'd0}]};
    endfunction

    function automatic logic [WORD_BITS-1:0] ref_load(input ex_mem_t it);
        logic [DM_ADDR_BITS-1:0] a;
        logic [7:0]              b;
        logic [15:0]             h;
        a = it.alu_result[DM_ADDR_BITS-1:0];
        b = ref_mem[a];
        h = {ref_mem[{a[DM_ADDR_BITS-1:1], 1'b1}], ref_mem[{a[DM_ADDR_BITS-1:1], 1'b0}]};
        if (it.size == SIZE_BYTE) return it.load_unsigned ? {24'd0, b} : {{24{b[7]}}, b};
        if (it.size == SIZE_HALF) return it.load_unsigned ? {16'd0, h} : {{16{h[15]}}, h};
        return ref_word(a);
    endfunction

    task automatic ref_store(input ex_mem_t it);
        logic [DM_ADDR_BITS-1:0] a;
        a = it.alu_result[DM_ADDR_BITS-1:0];
        if (it.size == SIZE_BYTE) begin
            ref_mem[a] = it.store_data[7:0];
        end else if (it.size == SIZE_HALF) begin
            ref_mem[{a[DM_ADDR_BITS-1:1], 1'b0}] = it.store_data[7:0];
            ref_mem[{a[DM_ADDR_BITS-1:1], 1'b1}] = it.store_data[15:8];
        end else begin
            for (int k = 0; k < 4; k++) begin
                ref_mem[{a[DM_ADDR_BITS-1:2], 2'(k)}] = it.store_data[8*k +: 8];
            end
        end
    endtask

    // Expected write-back bundle in handshake order
    task automatic model_accept(input ex_mem_t it);
        mem_wb_t             wb;
        logic [REG_BITS-1:0] d;
        if (it.mem_write) ref_store(it);
        d = it.link_r31 ? 5'd31 : it.dest;
        wb.wb_data   = it.link_r31 ? it.pc + 32'd8 : (it.mem_to_reg ? ref_load(it) : it.alu_result);
        wb.dest      = d;
        wb.reg_write = it.reg_write && (d != 5'd0);
        wb.halt      = it.halt;
        exp_q.push_back(wb);
        if (it.branch && it.zero) branch_q.push_back(it.branch_target);
    endtask

    function automatic ex_mem_t make_item(input int kind);
        ex_mem_t it;
        it = '0;
        it.alu_result    = $urandom;  // Upper bits lie outside the memory
        it.store_data    = $urandom;
        it.branch_target = $urandom;
        it.pc            = $urandom;
        it.dest          = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
        it.size          = access_size_e'(2'($urandom_range(0, 2)));
        it.load_unsigned = 1'($urandom_range(0, 1));
        case (kind)
            KIND_STORE: it.mem_write = 1'b1;
            KIND_LOAD: begin
                it.mem_read   = 1'b1;
                it.mem_to_reg = 1'b1;
                it.reg_write  = 1'b1;
            end
            KIND_ALU: it.reg_write = 1'b1;
            KIND_LINK: begin
                it.link_r31  = 1'b1;
                it.reg_write = 1'b1;
            end
            KIND_BRANCH: begin
                it.branch = 1'b1;
                it.zero   = 1'($urandom_range(0, 1));
            end
            default: it.halt = 1'b1;
        endcase
        return it;
    endfunction

    task automatic issue_item(input ex_mem_t it);
        in_item  <= it;
        in_valid <= 1'b1;
        do begin
            @(posedge clock);
        end while (!in_ready);
        in_valid <= 1'b0;  // Overridden by a back-to-back issue
    endtask

    task automatic wait_drain();
        do begin
            @(negedge clock);
        end while (exp_q.size() != 0);
        if (branch_q.size() != 0) note_error("branch pulses missing for taken branches");
        branch_q.delete();
        @(posedge clock);
    endtask

    task automatic run_random(input int n, input int kind_lo, input int kind_hi);
        for (int i = 0; i < n; i++) begin
            issue_item(make_item(int'($urandom_range(kind_lo, kind_hi))));
        end
        wait_drain();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic drive_out_ready();
        forever begin
            @(posedge clock);
            out_ready <= (int'($urandom_range(0, 99)) < ready_pct);
        end
    endtask

    // Scoreboard, branch and halt monitor
    always @(posedge clock) begin
        cycle_count++;
        if (arst_n) begin
            if (in_valid && in_ready) model_accept(in_item);
            if (out_hold) begin
                check_value("o_out_valid", 64'(out_valid), 64'(1));
                check_value("o_out", 64'(out_item), 64'(held_item));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    note_error("output handshake with no item outstanding");
                end else begin
                    exp_wb = exp_q.pop_front();
                    check_value("o_out", 64'(out_item), 64'(exp_wb));
                end
            end
            if (branch_taken) begin
                if (branch_q.size() == 0) begin
                    note_error("branch pulse without a taken branch");
                end else begin
                    check_value("o_branch_addr", 64'(branch_addr), 64'(branch_q.pop_front()));
                end
            end
            if (halted_seen && !halted) note_error("o_halted fell after halt");
            if (halted && in_ready) note_error("o_in_ready high while halted");
            halted_seen = halted_seen | halted;
            out_hold    = out_valid && !out_ready;
            held_item   = out_item;
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int      errs;
        ex_mem_t st;
        ex_mem_t ld;
        void'($urandom(SEED));
        clock      = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_item    = '0;
        out_ready  = 1'b0;
        dbg_enable = 1'b0;
        dbg_addr   = '0;
        ref_mem    = '{default: 8'h00};
        fork
            drive_out_ready();
        join_none
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;

        errs = error_count;
        @(negedge clock);
        check_value("o_in_ready", 64'(in_ready), 64'(1));
        check_value("o_out_valid", 64'(out_valid), 64'(0));
        check_value("o_branch_taken", 64'(branch_taken), 64'(0));
        check_value("o_halted", 64'(halted), 64'(0));
        @(posedge clock);
        for (int i = 0; i < N_PAIRS; i++) begin
            st = make_item(KIND_STORE);
            ld = make_item(KIND_LOAD);
            ld.alu_result    = st.alu_result;
            ld.size          = access_size_e'(2'(i % 3));  // Cycle sizes and signedness
            ld.load_unsigned = 1'((i / 3) % 2);
            issue_item(st);
            issue_item(ld);
        end
        wait_drain();
        finish_test("store_load", errs);

        errs = error_count;
        run_random(N_ALU, KIND_ALU, KIND_LINK);
        finish_test("alu_link", errs);

        errs = error_count;
        ready_pct <= 40;
        run_random(N_MIX, KIND_STORE, KIND_BRANCH);
        finish_test("backpressure", errs);

        errs = error_count;
        ready_pct <= 75;
        run_random(N_BRANCH, KIND_BRANCH, KIND_BRANCH);
        finish_test("branch", errs);

        errs = error_count;
        run_random(N_STORES, KIND_STORE, KIND_STORE);
        for (int i = 0; i < N_DEBUG; i++) begin
            dbg_enable <= 1'b1;
            dbg_addr   <= DM_ADDR_BITS'($urandom_range(0, 2**DM_ADDR_BITS - 1));
            @(negedge clock);
            check_value("o_dbg_word", 64'(dbg_word), 64'(ref_word(dbg_addr)));
            @(posedge clock);
        end
        dbg_enable <= 1'b0;
        @(negedge clock);
        check_value("o_dbg_word", 64'(dbg_word), 64'(0));
        @(posedge clock);
        finish_test("debug_read", errs);

        errs = error_count;
        ready_pct <= 60;
        for (int i = 0; i < N_PRE_HALT; i++) begin
            issue_item(make_item(int'($urandom_range(KIND_STORE, KIND_BRANCH))));
        end
        issue_item(make_item(KIND_HALT));
        in_item  <= make_item(KIND_ALU);  // Offered but never taken
        in_valid <= 1'b1;
        repeat (8) begin
            @(negedge clock);
            check_value("o_in_ready", 64'(in_ready), 64'(0));
        end
        @(posedge clock);
        in_valid <= 1'b0;
        wait_drain();
        repeat (4) @(negedge clock);
        check_value("o_halted", 64'(halted), 64'(1));
        check_value("o_in_ready", 64'(in_ready), 64'(0));
        finish_test("halt", errs);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/mem_stage_pkg.sv
src/pipe_reg.sv
mem_stage/mem_stage_ctrl.sv
mem_stage/data_memory.sv
mem_stage/load_extend.sv
src/writeback_select.sv
src/mem_top.sv
tests/mem_top_assertions.sv
tests/tb_mem_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_mem_top -Mdir obj_dir -o sim

# A crash or a failed assertion also counts as a failure
run: compile
	./obj_dir/sim > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
